// File: sim.f
+incdir+.
hog_pkg.sv
hog_context.sv
hog_gradient.sv
hog_magnitude.sv
hog_top.sv
tb_hog.sv

// File: Bender.yml
package:
  name: hog_gradient_tiles

sources:
  - hog_pkg.sv
  - hog_context.sv
  - hog_gradient.sv
  - hog_magnitude.sv
  - hog_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_hog.sv

// File: tb_hog_ref.svh
`ifndef TB_HOG_REF_SVH
`define TB_HOG_REF_SVH

////////////////////
// reference model

// whole frame in global pixel coordinates
pixel_t ref_img [IMG_TILE_ROWS*TILE_H][IMG_TILE_COLS*TILE_W];

// position of the next tile to be accepted
int ref_col;
int ref_row;

// expected tiles and the cycle each input was taken
mag_tile_t exp_q [$];
int        exp_cyc_q [$];

// stores a tile into the frame image and queues its expected magnitudes
task automatic ref_accept(input pix_tile_t t, input int cyc);
	mag_tile_t m;
	int        y0;
	int        x0;
	int        y;
	int        x;
	int        px;
	int        lx;
	int        uy;
	int        gx;
	int        gy;
	y0 = ref_row * TILE_H;
	x0 = ref_col * TILE_W;
	for (int r = 0; r < TILE_H; r++) begin
		for (int c = 0; c < TILE_W; c++) begin
			ref_img[y0+r][x0+c] = t[r][c];
		end
	end
	// earlier neighbours of this frame are already in the image
	for (int r = 0; r < TILE_H; r++) begin
		for (int c = 0; c < TILE_W; c++) begin
			y = y0 + r;
			x = x0 + c;
			px = ref_img[y][x];
			lx = (x == 0) ? px : ref_img[y][x-1];
			uy = (y == 0) ? px : ref_img[y-1][x];
			gx = px - lx;
			gy = px - uy;
			m[r][c] = mag_t'(gx * gx + gy * gy);
		end
	end
	exp_q.push_back(m);
	exp_cyc_q.push_back(cyc);
	// raster order, wrap at end of frame
	if (ref_col == IMG_TILE_COLS - 1) begin
		ref_col = 0;
		ref_row = (ref_row == IMG_TILE_ROWS - 1) ? 0 : ref_row + 1;
	end else begin
		ref_col = ref_col + 1;
	end
endtask

`endif

// File: tb_hog.sv
`timescale 1ns/1ns

module tb_hog;
	import hog_pkg::*;

	localparam int IMG_TILE_COLS = 6;
	localparam int IMG_TILE_ROWS = 4;
	localparam int WAIT_LIMIT    = 200;

	localparam int FRAME_RANDOM = 0;
	localparam int FRAME_COLS   = 1;
	localparam int FRAME_ROWS   = 2;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	pix_tile_t in_tile;
	logic      out_valid;
	logic      out_ready;
	mag_tile_t out_mag;

	logic [31:0] lfsr;
	int          cycle;
	int          value_errors;
	int          protocol_errors;
	int          timeout_errors;
	int          stall_cycles;
	bit          check_latency;
	bit          throttle;

	`include "tb_hog_ref.svh"

	hog_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_tile  (in_tile),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_mag  (out_mag)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// random source

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic pix_tile_t rand_tile();
		pix_tile_t t;
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				t[r][c] = pixel_t'(rand_bits(PIX_W));
			end
		end
		return t;
	endfunction

	// pixels depend on the global column only, or on the global row only
	function automatic pix_tile_t pattern_tile(input int tr, input int tc, input bit by_row);
		pix_tile_t t;
		int        x;
		int        y;
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				x = tc * TILE_W + c;
				y = tr * TILE_H + r;
				if (by_row) begin
					t[r][c] = pixel_t'((y * 53 + 5) % 256);
				end else begin
					t[r][c] = pixel_t'((x * 37 + 11) % 256);
				end
			end
		end
		return t;
	endfunction

	////////////////////
	// stimulus

	task automatic next_cycle();
		logic [31:0] b;
		@(negedge clk);
		if (throttle) begin
			b = rand_bits(1);
			out_ready = b[0];
		end else begin
			out_ready = 1'b1;
		end
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
		end
	endtask

	// holds the tile until the edge that takes it
	task automatic send_tile(input pix_tile_t t);
		int n;
		bit taken;
		in_valid = 1'b1;
		in_tile = t;
		n = 0;
		taken = 1'b0;
		while (!taken && n < WAIT_LIMIT) begin
			@(posedge clk);
			taken = in_ready;
			n++;
			next_cycle();
		end
		if (!taken) begin
			timeout_errors++;
			$display("timeout: tile not accepted within %0d cycles", WAIT_LIMIT);
		end
		in_valid = 1'b0;
	endtask

	task automatic send_frame(input int kind, input bit gaps);
		pix_tile_t   t;
		logic [31:0] r;
		for (int tr = 0; tr < IMG_TILE_ROWS; tr++) begin
			for (int tc = 0; tc < IMG_TILE_COLS; tc++) begin
				case (kind)
					FRAME_COLS: t = pattern_tile(tr, tc, 1'b0);
					FRAME_ROWS: t = pattern_tile(tr, tc, 1'b1);
					default:    t = rand_tile();
				endcase
				send_tile(t);
				if (gaps) begin
					r = rand_bits(2);
					if (r == 0) begin
						idle(int'(rand_bits(2)) + 1);
					end
				end
			end
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			timeout_errors++;
			$display("timeout: %0d tiles still pending after %0d cycles", exp_q.size(), n);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			protocol_errors++;
			$display("mismatch t=%0t %s exp=%b got=%b", $time, name, exp, got);
		end
	endtask

	////////////////////
	// monitor and scoreboard

	always @(posedge clk) begin : monitor
		mag_tile_t exp;
		int        lat;
		cycle++;
		if (rst_n) begin
			// ready falls only with all three registers full and no drain
			assert (in_ready === !(exp_q.size() == 3 && !out_ready)) else begin
				protocol_errors++;
				$display("mismatch t=%0t in_ready exp=%b got=%b", $time,
					!(exp_q.size() == 3 && !out_ready), in_ready);
			end
			if (!in_ready) begin
				stall_cycles++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("output tile at t=%0t with no tile pending", $time);
				end else begin
					exp = exp_q.pop_front();
					lat = cycle - exp_cyc_q.pop_front();
					for (int r = 0; r < TILE_H; r++) begin
						for (int c = 0; c < TILE_W; c++) begin
							assert (out_mag[r][c] === exp[r][c]) else begin
								value_errors++;
								$display("mismatch t=%0t out_mag[%0d][%0d] exp=%0d got=%0d",
									$time, r, c, exp[r][c], out_mag[r][c]);
							end
						end
					end
					if (check_latency) begin
						assert (lat == 3) else begin
							protocol_errors++;
							$display("mismatch t=%0t latency exp=3 got=%0d", $time, lat);
						end
					end
				end
			end
			if (in_valid && in_ready) begin
				ref_accept(in_tile, cycle);
			end
		end
	end

	////////////////////
	// test sequence

	initial begin
		lfsr = 32'hf2de;
		cycle = 0;
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		stall_cycles = 0;
		check_latency = 1'b0;
		throttle = 1'b0;
		ref_col = 0;
		ref_row = 0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_tile = '0;
		out_ready = 1'b1;

		repeat (2) begin
			@(posedge clk);
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("in_ready", in_ready, 1'b1);
		end
		rst_n = 1'b1;
		next_cycle();
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);

		// back to back with no stalls and fixed latency
		check_latency = 1'b1;
		send_frame(FRAME_RANDOM, 1'b0);
		drain();
		check_latency = 1'b0;

		// first pattern tile follows a frame wrap and must ignore the old line buffer
		send_frame(FRAME_COLS, 1'b0);
		send_frame(FRAME_ROWS, 1'b0);
		drain();

		// random back-pressure and input gaps
		throttle = 1'b1;
		send_frame(FRAME_RANDOM, 1'b1);
		drain();
		throttle = 1'b0;
		out_ready = 1'b1;
		assert (stall_cycles > 0) else begin
			protocol_errors++;
			$display("in_ready never dropped while the output was stalled");
		end

		// one more wrap back to the frame corner
		send_frame(FRAME_COLS, 1'b0);
		drain();

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: hog_top.sv
`timescale 1ns/1ns

module hog_top #(
	parameter int IMG_TILE_COLS = 6,
	parameter int IMG_TILE_ROWS = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  hog_pkg::pix_tile_t in_tile,
	output logic               out_valid,
	input  logic               out_ready,
	output hog_pkg::mag_tile_t out_mag
);
	import hog_pkg::*;

	// context to gradient
	logic       ctx_valid;
	logic       ctx_ready;
	ctx_tile_t  ctx;

	// gradient to magnitude
	logic       grad_valid;
	logic       grad_ready;
	grad_tile_t grad;

	////////////////////
	// pipeline, one register per stage

	hog_context #(
		.IMG_TILE_COLS(IMG_TILE_COLS),
		.IMG_TILE_ROWS(IMG_TILE_ROWS)
	) u_context (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_tile  (in_tile),
		.ctx_valid(ctx_valid),
		.ctx_ready(ctx_ready),
		.ctx      (ctx)
	);

	hog_gradient u_gradient (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctx_valid (ctx_valid),
		.ctx_ready (ctx_ready),
		.ctx       (ctx),
		.grad_valid(grad_valid),
		.grad_ready(grad_ready),
		.grad      (grad)
	);

	hog_magnitude u_magnitude (
		.clk       (clk),
		.rst_n     (rst_n),
		.grad_valid(grad_valid),
		.grad_ready(grad_ready),
		.grad      (grad),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_mag   (out_mag)
	);

endmodule

// File: hog_magnitude.sv
`timescale 1ns/1ns

module hog_magnitude (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                grad_valid,
	output logic                grad_ready,
	input  hog_pkg::grad_tile_t grad,
	output logic                out_valid,
	input  logic                out_ready,
	output hog_pkg::mag_tile_t  out_mag
);
	import hog_pkg::*;

	logic      accept;
	mag_tile_t mag_d;

	// square of a signed difference, always fits in MAG_W-1 bits
	function automatic mag_t sq(input grad_t g);
		logic signed [2*GRAD_W-1:0] p;
		p = g * g;
		return mag_t'(p);
	endfunction

	assign grad_ready = !out_valid || out_ready;
	assign accept     = grad_valid && grad_ready;

	////////////////////
	// gx^2 + gy^2

	always_comb begin
		for (int r = 0; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				mag_d[r][c] = sq(grad.gx[r][c]) + sq(grad.gy[r][c]);
			end
		end
	end

	////////////////////
	// output register

	// holds while out_ready is low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (grad_ready) begin
			out_valid <= grad_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_mag <= mag_d;
		end
	end

endmodule

// File: hog_gradient.sv
`timescale 1ns/1ns

module hog_gradient (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ctx_valid,
	output logic                ctx_ready,
	input  hog_pkg::ctx_tile_t  ctx,
	output logic                grad_valid,
	input  logic                grad_ready,
	output hog_pkg::grad_tile_t grad
);
	import hog_pkg::*;

	logic       accept;
	grad_tile_t grad_d;

	// pixel minus neighbour, both zero extended
	function automatic grad_t diff(input pixel_t px, input pixel_t nb);
		grad_t a;
		grad_t b;
		a = grad_t'({1'b0, px});
		b = grad_t'({1'b0, nb});
		return a - b;
	endfunction

	assign ctx_ready = !grad_valid || grad_ready;
	assign accept    = ctx_valid && ctx_ready;

	////////////////////
	// differences

	always_comb begin
		// gx, column 0 takes the left word
		for (int r = 0; r < TILE_H; r++) begin
			grad_d.gx[r][0] = diff(ctx.tile[r][0], ctx.left[r]);
			for (int c = 1; c < TILE_W; c++) begin
				grad_d.gx[r][c] = diff(ctx.tile[r][c], ctx.tile[r][c-1]);
			end
		end

		// gy, row 0 takes the above word
		for (int c = 0; c < TILE_W; c++) begin
			grad_d.gy[0][c] = diff(ctx.tile[0][c], ctx.above[c]);
		end
		for (int r = 1; r < TILE_H; r++) begin
			for (int c = 0; c < TILE_W; c++) begin
				grad_d.gy[r][c] = diff(ctx.tile[r][c], ctx.tile[r-1][c]);
			end
		end
	end

	////////////////////
	// stage register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grad_valid <= 1'b0;
		end else if (ctx_ready) begin
			grad_valid <= ctx_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			grad <= grad_d;
		end
	end

endmodule

// File: hog_context.sv
`timescale 1ns/1ns

module hog_context #(
	parameter int IMG_TILE_COLS = 6,
	parameter int IMG_TILE_ROWS = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  hog_pkg::pix_tile_t in_tile,
	output logic               ctx_valid,
	input  logic               ctx_ready,
	output hog_pkg::ctx_tile_t ctx
);
	import hog_pkg::*;

	localparam int COL_W = (IMG_TILE_COLS > 1) ? $clog2(IMG_TILE_COLS) : 1;
	localparam int ROW_W = (IMG_TILE_ROWS > 1) ? $clog2(IMG_TILE_ROWS) : 1;

	typedef logic [COL_W-1:0] tile_col_t;
	typedef logic [ROW_W-1:0] tile_row_t;

	tile_col_t col_cnt;
	tile_row_t row_cnt;
	logic      accept;

	// bottom rows of the tile row above, one entry per tile column
	pix_row_t line_buf [IMG_TILE_COLS];

	// right column of the previous tile
	pix_col_t carry;

	pix_row_t above;
	pix_col_t left;

	assign in_ready = !ctx_valid || ctx_ready;
	assign accept   = in_valid && in_ready;

	////////////////////
	// neighbour select

	// frame edge uses the tile's own pixels, so the difference is zero
	always_comb begin
		if (row_cnt == '0) begin
			above = in_tile[0];
		end else begin
			above = line_buf[col_cnt];
		end
		for (int r = 0; r < TILE_H; r++) begin
			if (col_cnt == '0) begin
				left[r] = in_tile[r][0];
			end else begin
				left[r] = carry[r];
			end
		end
	end

	////////////////////
	// tile position

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (accept) begin
			if (col_cnt == tile_col_t'(IMG_TILE_COLS - 1)) begin
				col_cnt <= '0;
				// wrap at end of frame
				if (row_cnt == tile_row_t'(IMG_TILE_ROWS - 1)) begin
					row_cnt <= '0;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// neighbour storage for later tiles
	always_ff @(posedge clk) begin
		if (accept) begin
			line_buf[col_cnt] <= in_tile[TILE_H-1];
			for (int r = 0; r < TILE_H; r++) begin
				carry[r] <= in_tile[r][TILE_W-1];
			end
		end
	end

	////////////////////
	// stage register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctx_valid <= 1'b0;
		end else if (in_ready) begin
			ctx_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ctx.tile  <= in_tile;
			ctx.above <= above;
			ctx.left  <= left;
		end
	end

endmodule

// File: hog_pkg.sv
package hog_pkg;

	////////////////////
	// tile geometry

	localparam int TILE_H = 3;
	localparam int TILE_W = 4;
	localparam int PIX_W  = 8;

	// derived widths
	localparam int GRAD_W = PIX_W + 1;
	localparam int MAG_W  = 2 * PIX_W + 1;

	////////////////////
	// scalar types

	// unsigned grey value
	typedef logic [PIX_W-1:0] pixel_t;

	// difference of two pixels, -255 .. 255
	typedef logic signed [GRAD_W-1:0] grad_t;

	// gx^2 + gy^2, at most 2 * 255^2
	typedef logic [MAG_W-1:0] mag_t;

	////////////////////
	// tile arrays

	typedef pixel_t [TILE_W-1:0] pix_row_t;
	typedef pixel_t [TILE_H-1:0] pix_col_t;

	// row then column
	typedef pix_row_t [TILE_H-1:0] pix_tile_t;

	typedef grad_t [TILE_H-1:0][TILE_W-1:0] grad_arr_t;
	typedef mag_t [TILE_H-1:0][TILE_W-1:0] mag_tile_t;

	// tile plus its resolved neighbours
	typedef struct packed {
		pix_tile_t tile;
		pix_row_t  above;
		pix_col_t  left;
	} ctx_tile_t;

	typedef struct packed {
		grad_arr_t gx;
		grad_arr_t gy;
	} grad_tile_t;

endpackage
